/* rtl/raster_pkg.sv */
/*
 * Raster display shared definitions
 * Host command word layout, opcodes, pixel format and parser states
 */
package raster_pkg;

    localparam int WORD_BITS  = 32;
    localparam int PIXEL_BITS = 16;

    // One host word, opcode in 31..24 and payload in 23..0
    typedef logic [WORD_BITS-1:0] cmd_word_t;

    // RGB565
    typedef logic [PIXEL_BITS-1:0] pixel_t;

    typedef logic [7:0] opcode_t;

    // Pixel count of a write command
    typedef logic [7:0] run_len_t;

    //////////////////////////////
    // Host opcodes
    //////////////////////////////
    localparam opcode_t OP_FILL  = 8'h01;
    localparam opcode_t OP_WRITE = 8'h02;
    localparam opcode_t OP_FLUSH = 8'h03;

    // Display controller memory write command
    localparam logic [7:0] DISP_MEMORY_WRITE = 8'h2C;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FILL,
        ST_WRITE,
        ST_FLUSH
    } parser_state_t;

endpackage

/* rtl/serial_word_rx.sv */
/*
 * Host serial word receiver
 * Samples the slave serial link and collects 32-bit words into a
 * one-word holding register, with cts high while that register is empty
 */
module serial_word_rx (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  serial_sck,
    input  logic                  serial_mosi,
    input  logic                  serial_cs,
    output logic                  serial_cts,
    output raster_pkg::cmd_word_t word_data,
    output logic                  word_valid,
    input  logic                  word_ready
);
    import raster_pkg::*;

    logic [1:0] sck_sync;
    logic [1:0] mosi_sync;
    logic [1:0] cs_sync;
    logic       sck_d;
    logic       sck_rise;

    // Shift register holds the first 31 bits, the last one goes straight to the holding reg
    logic [WORD_BITS-2:0] shift_q;
    logic [4:0]           bit_cnt;

    //////////////////////////////
    // Pin synchronisers
    //////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sck_sync  <= 2'b00;
            mosi_sync <= 2'b00;
            cs_sync   <= 2'b11;
            sck_d     <= 1'b0;
        end
        else
        begin
            sck_sync  <= {sck_sync[0], serial_sck};
            mosi_sync <= {mosi_sync[0], serial_mosi};
            cs_sync   <= {cs_sync[0], serial_cs};
            sck_d     <= sck_sync[1];
        end
    end

    assign sck_rise = sck_sync[1] && !sck_d && !cs_sync[1];

    //////////////////////////////
    // Word assembly
    //////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            bit_cnt    <= '0;
            word_valid <= 1'b0;
        end
        else
        begin
            if (word_valid && word_ready)
            begin
                word_valid <= 1'b0;
            end
            if (cs_sync[1])
            begin
                // Deselect drops any partial word
                bit_cnt <= '0;
            end
            else if (sck_rise)
            begin
                shift_q <= {shift_q[WORD_BITS-3:0], mosi_sync[1]};
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 5'd31)
                begin
                    word_data  <= {shift_q, mosi_sync[1]};
                    word_valid <= 1'b1;
                end
            end
        end
    end

    assign serial_cts = !word_valid;

endmodule

/* rtl/cmd_parser_fsm.sv */
/*
 * Command parser
 * Decodes host words into tile fill, pixel run writes and display flush
 */
module cmd_parser_fsm #(
    parameter int TILE_PIXELS = 32
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  raster_pkg::cmd_word_t          word_data,
    input  logic                           word_valid,
    output logic                           word_ready,
    output logic                           wr_en,
    output logic [$clog2(TILE_PIXELS)-1:0] wr_addr,
    output raster_pkg::pixel_t             wr_pixel,
    output logic                           flush_start,
    input  logic                           flush_busy
);
    import raster_pkg::*;

    localparam int ADDR_W = $clog2(TILE_PIXELS);

    parser_state_t     state_q;
    parser_state_t     state_d;
    opcode_t           opcode;
    run_len_t          run_len;
    run_len_t          count_q;
    pixel_t            colour_q;
    logic [ADDR_W-1:0] addr_q;
    logic              accept;

    assign accept  = word_valid && word_ready;
    assign opcode  = word_data[31:24];
    assign run_len = word_data[23:16];

    //////////////////////////////
    // Next state
    //////////////////////////////
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:
            begin
                if (accept)
                begin
                    if (opcode == OP_FILL)
                        state_d = ST_FILL;
                    else if (opcode == OP_WRITE && run_len != '0)
                        state_d = ST_WRITE;
                    else if (opcode == OP_FLUSH)
                        state_d = ST_FLUSH;
                end
            end
            ST_FILL:
            begin
                if (addr_q == ADDR_W'(TILE_PIXELS - 1))
                    state_d = ST_IDLE;
            end
            ST_WRITE:
            begin
                if (accept && count_q == run_len_t'(1))
                    state_d = ST_IDLE;
            end
            ST_FLUSH:
            begin
                if (!flush_busy)
                    state_d = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q    <= ST_IDLE;
            word_ready <= 1'b0;
            addr_q     <= '0;
            count_q    <= '0;
        end
        else
        begin
            state_q    <= state_d;
            // Ready registered from the next state so it is low during reset
            word_ready <= (state_d == ST_IDLE) || (state_d == ST_WRITE);
            if (state_q == ST_IDLE && accept)
            begin
                addr_q  <= (opcode == OP_WRITE) ? word_data[ADDR_W-1:0] : '0;
                count_q <= run_len;
            end
            else if (wr_en)
            begin
                // Wraps modulo the tile size
                addr_q  <= addr_q + 1'b1;
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Fill colour
    always_ff @(posedge clk)
    begin
        if (state_q == ST_IDLE && accept && opcode == OP_FILL)
            colour_q <= word_data[PIXEL_BITS-1:0];
    end

    assign wr_en       = (state_q == ST_FILL) || (state_q == ST_WRITE && accept);
    assign wr_addr     = addr_q;
    assign wr_pixel    = (state_q == ST_FILL) ? colour_q : word_data[PIXEL_BITS-1:0];
    assign flush_start = (state_q == ST_IDLE) && accept && (opcode == OP_FLUSH);

endmodule

/* rtl/tile_buffer.sv */
/*
 * Tile pixel memory
 * Single write port, plus a flush reader streaming every pixel in order
 */
module tile_buffer #(
    parameter int TILE_PIXELS = 32
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wr_en,
    input  logic [$clog2(TILE_PIXELS)-1:0] wr_addr,
    input  raster_pkg::pixel_t             wr_pixel,
    input  logic                           flush_start,
    output logic                           flush_busy,
    output raster_pkg::pixel_t             pix_data,
    output logic                           pix_valid,
    input  logic                           pix_ready,
    output logic                           pix_last
);
    import raster_pkg::*;

    localparam int                ADDR_W    = $clog2(TILE_PIXELS);
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(TILE_PIXELS - 1);

    pixel_t            mem [TILE_PIXELS];
    logic [ADDR_W-1:0] rd_addr;
    logic              reading;
    logic              load;

    // Fetch only when the output register is free or draining
    assign load = reading && (!pix_valid || pix_ready);

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_pixel;
        if (load)
            pix_data <= mem[rd_addr];
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            reading    <= 1'b0;
            rd_addr    <= '0;
            pix_valid  <= 1'b0;
            pix_last   <= 1'b0;
            flush_busy <= 1'b0;
        end
        else
        begin
            if (flush_start)
            begin
                reading    <= 1'b1;
                rd_addr    <= '0;
                flush_busy <= 1'b1;
            end
            else if (load)
            begin
                rd_addr <= rd_addr + 1'b1;
                if (rd_addr == LAST_ADDR)
                    reading <= 1'b0;
            end

            if (load)
            begin
                pix_valid <= 1'b1;
                pix_last  <= (rd_addr == LAST_ADDR);
            end
            else if (pix_ready)
            begin
                pix_valid <= 1'b0;
            end

            // Frame ends once the transmitter takes the last pixel
            if (pix_valid && pix_ready && pix_last)
                flush_busy <= 1'b0;
        end
    end

endmodule

/* rtl/spi_bit_timer.sv */
/*
 * SPI bit timer
 * Paces the SPI clock phases and counts the bits of one byte or pixel
 */
module spi_bit_timer #(
    parameter int CLOCK_DIV = 2
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic [4:0] bit_count_total,
    output logic       sck_rise,
    output logic       sck_fall,
    output logic       word_done
);
    localparam int DIV_W = $clog2(CLOCK_DIV + 1);

    logic             running;
    logic             phase;
    logic [DIV_W-1:0] div_cnt;
    logic [4:0]       bit_cnt;
    logic             tick;

    assign tick      = running && (div_cnt == DIV_W'(CLOCK_DIV - 1));
    assign sck_rise  = tick && !phase;
    assign sck_fall  = tick && phase;
    // The fall that follows the last rise closes the word
    assign word_done = sck_fall && (bit_cnt == bit_count_total);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            running <= 1'b0;
            phase   <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
        end
        else if (start)
        begin
            running <= 1'b1;
            phase   <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
        end
        else if (tick)
        begin
            div_cnt <= '0;
            phase   <= !phase;
            if (!phase)
                bit_cnt <= bit_cnt + 1'b1;
            if (word_done)
                running <= 1'b0;
        end
        else if (running)
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

/* rtl/display_spi_tx.sv */
/*
 * Display SPI transmitter
 * Mode 0 shifter sending the memory write command, then the pixel stream
 */
module display_spi_tx #(
    parameter int CLOCK_DIV = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  raster_pkg::pixel_t pix_data,
    input  logic               pix_valid,
    output logic               pix_ready,
    input  logic               pix_last,
    output logic               display_sck,
    output logic               display_mosi,
    output logic               display_cs,
    output logic               display_dc
);
    import raster_pkg::*;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_SELECT,
        TX_CMD,
        TX_LOAD,
        TX_PIXEL,
        TX_RELEASE
    } tx_state_t;

    tx_state_t  state_q;
    pixel_t     shift_q;
    logic       last_q;
    logic       start;
    logic [4:0] bit_count_total;
    logic       sck_rise;
    logic       sck_fall;
    logic       word_done;

    assign pix_ready       = (state_q == TX_LOAD);
    assign start           = (state_q == TX_SELECT) || (pix_ready && pix_valid);
    assign bit_count_total = (state_q == TX_CMD || state_q == TX_SELECT) ? 5'd8 : 5'd16;
    assign display_mosi    = shift_q[PIXEL_BITS-1];

    spi_bit_timer #(
        .CLOCK_DIV(CLOCK_DIV)
    ) spi_bit_timer_inst (
        .clk(clk),
        .rst_n(rst_n),
        .start(start),
        .bit_count_total(bit_count_total),
        .sck_rise(sck_rise),
        .sck_fall(sck_fall),
        .word_done(word_done)
    );

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q     <= TX_IDLE;
            shift_q     <= '0;
            last_q      <= 1'b0;
            display_sck <= 1'b0;
            display_cs  <= 1'b1;
            display_dc  <= 1'b1;
        end
        else
        begin
            if (sck_rise)
                display_sck <= 1'b1;
            if (sck_fall)
                display_sck <= 1'b0;

            case (state_q)
                TX_IDLE:
                begin
                    // First pixel of a frame selects the display
                    if (pix_valid)
                    begin
                        display_cs <= 1'b0;
                        state_q    <= TX_SELECT;
                    end
                end
                TX_SELECT:
                begin
                    shift_q    <= {DISP_MEMORY_WRITE, 8'h00};
                    display_dc <= 1'b0;
                    state_q    <= TX_CMD;
                end
                TX_LOAD:
                begin
                    if (pix_valid)
                    begin
                        shift_q    <= pix_data;
                        last_q     <= pix_last;
                        display_dc <= 1'b1;
                        state_q    <= TX_PIXEL;
                    end
                end
                TX_CMD, TX_PIXEL:
                begin
                    if (word_done)
                        state_q <= (state_q == TX_PIXEL && last_q) ? TX_RELEASE : TX_LOAD;
                    else if (sck_fall)
                        shift_q <= {shift_q[PIXEL_BITS-2:0], 1'b0};
                end
                TX_RELEASE:
                begin
                    display_cs <= 1'b1;
                    display_dc <= 1'b1;
                    state_q    <= TX_IDLE;
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

endmodule

/* rtl/raster_display_top.sv */
/*
 * Raster display path top level
 * Host serial link to command parser, tile buffer and SPI display
 */
module raster_display_top #(
    parameter int TILE_PIXELS = 32,
    parameter int CLOCK_DIV   = 2
) (
    input  logic clk,
    input  logic rst_n,
    input  logic serial_sck,
    input  logic serial_mosi,
    input  logic serial_cs,
    output logic serial_cts,
    output logic display_sck,
    output logic display_mosi,
    output logic display_cs,
    output logic display_dc
);
    import raster_pkg::*;

    localparam int ADDR_W = $clog2(TILE_PIXELS);

    // Host words
    cmd_word_t word_data;
    logic      word_valid;
    logic      word_ready;

    // Tile write port and flush control
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    pixel_t            wr_pixel;
    logic              flush_start;
    logic              flush_busy;

    // Pixel stream
    pixel_t pix_data;
    logic   pix_valid;
    logic   pix_ready;
    logic   pix_last;

    serial_word_rx serial_word_rx_inst (
        .clk(clk),
        .rst_n(rst_n),
        .serial_sck(serial_sck),
        .serial_mosi(serial_mosi),
        .serial_cs(serial_cs),
        .serial_cts(serial_cts),
        .word_data(word_data),
        .word_valid(word_valid),
        .word_ready(word_ready)
    );

    cmd_parser_fsm #(
        .TILE_PIXELS(TILE_PIXELS)
    ) cmd_parser_fsm_inst (
        .clk(clk),
        .rst_n(rst_n),
        .word_data(word_data),
        .word_valid(word_valid),
        .word_ready(word_ready),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_pixel(wr_pixel),
        .flush_start(flush_start),
        .flush_busy(flush_busy)
    );

    tile_buffer #(
        .TILE_PIXELS(TILE_PIXELS)
    ) tile_buffer_inst (
        .clk(clk),
        .rst_n(rst_n),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_pixel(wr_pixel),
        .flush_start(flush_start),
        .flush_busy(flush_busy),
        .pix_data(pix_data),
        .pix_valid(pix_valid),
        .pix_ready(pix_ready),
        .pix_last(pix_last)
    );

    display_spi_tx #(
        .CLOCK_DIV(CLOCK_DIV)
    ) display_spi_tx_inst (
        .clk(clk),
        .rst_n(rst_n),
        .pix_data(pix_data),
        .pix_valid(pix_valid),
        .pix_ready(pix_ready),
        .pix_last(pix_last),
        .display_sck(display_sck),
        .display_mosi(display_mosi),
        .display_cs(display_cs),
        .display_dc(display_dc)
    );

endmodule

/* testbench/display_checker.sv */
/*
 * Display frame checker
 * Decodes SPI frames from the display pins, compares them with the
 * frames queued by the testbench and keeps the test counts
 */
module display_checker #(
    parameter int TILE_PIXELS = 32,
    parameter int BIT_LIMIT   = 400
) (
    input logic clk,
    input logic rst_n,
    input logic serial_cts,
    input logic display_sck,
    input logic display_mosi,
    input logic display_cs,
    input logic display_dc
);
    localparam logic [7:0] CMD_BYTE = 8'h2C;

    // A word taken at once holds cts low for a single clock
    localparam int STALL_MIN = 2;

    // One {cs, dc, mosi} entry per sck rise
    logic [2:0]  bit_q [$];
    logic [15:0] exp_q [$];
    string       name_q [$];

    int tests_run     = 0;
    int tests_failed  = 0;
    int error_count   = 0;
    int frames_done   = 0;
    int frame_errors  = 0;
    int cts_low_run   = 0;
    int longest_stall = 0;

    always @(posedge display_sck)
    begin
        if (rst_n)
            bit_q.push_back({display_cs, display_dc, display_mosi});
    end

    // Longest stretch of the host held off while a frame is on the wire
    always @(posedge clk)
    begin
        if (rst_n && !serial_cts && !display_cs)
        begin
            cts_low_run <= cts_low_run + 1;
            if (cts_low_run >= longest_stall)
                longest_stall <= cts_low_run + 1;
        end
        else
        begin
            cts_low_run <= 0;
        end
    end

    //////////////////////////////
    // Calls from the testbench
    //////////////////////////////
    task automatic push_pixel(input logic [15:0] pixel);
        exp_q.push_back(pixel);
    endtask

    // Queued after its pixels so a name means a complete frame
    task automatic push_frame(input string name);
        name_q.push_back(name);
    endtask

    task automatic check_stall(input string name);
        int errors;
        errors = 0;
        if (longest_stall < STALL_MIN)
        begin
            $display("Time %0t: serial_cts never held the host off while a frame was sent",
                     $time);
            errors = 1;
        end
        error_count += errors;
        finish_test(name, errors);
    endtask

    //////////////////////////////
    // Helpers
    //////////////////////////////
    task automatic finish_test(input string name, input int errors);
        tests_run++;
        if (errors == 0)
        begin
            $display("Test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("Test %s: %0d errors", name, errors);
        end
    endtask

    task automatic expect_level(input string signal, input logic actual,
                                input logic expected, inout int errors);
        if (actual !== expected)
        begin
            $display("Fail at time %0t: %s expected %b actual %b",
                     $time, signal, expected, actual);
            errors++;
        end
    endtask

    task automatic check_reset_state();
        int waited;
        int errors;
        waited = 0;
        errors = 0;
        while (rst_n !== 1'b1 && waited < BIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        @(negedge clk);
        if (rst_n !== 1'b1)
        begin
            $display("Time %0t: reset was never released", $time);
            errors++;
        end
        expect_level("display_cs", display_cs, 1'b1, errors);
        expect_level("display_sck", display_sck, 1'b0, errors);
        expect_level("display_dc", display_dc, 1'b1, errors);
        expect_level("serial_cts", serial_cts, 1'b1, errors);
        error_count += errors;
        finish_test("reset state", errors);
    endtask

    // Collects one byte or pixel MSB first
    task automatic get_bits(input int nbits, input logic want_dc, input string what,
                            output logic [15:0] value, output logic ok);
        logic [2:0] sample;
        logic       cs_bad;
        logic       dc_bad;
        int         waited;
        int         i;
        value  = '0;
        ok     = 1'b1;
        cs_bad = 1'b0;
        dc_bad = 1'b0;
        for (i = 0; i < nbits && ok; i++)
        begin
            waited = 0;
            while (bit_q.size() == 0 && waited < BIT_LIMIT)
            begin
                @(negedge clk);
                waited++;
            end
            if (bit_q.size() == 0)
            begin
                $display("Time %0t: no display_sck rise within %0d clocks during the %s",
                         $time, BIT_LIMIT, what);
                ok = 1'b0;
            end
            else
            begin
                sample = bit_q.pop_front();
                cs_bad = cs_bad || (sample[2] !== 1'b0);
                dc_bad = dc_bad || (sample[1] !== want_dc);
                value  = {value[14:0], sample[0]};
            end
        end
        if (!ok)
            frame_errors++;
        if (cs_bad)
        begin
            $display("Fail at time %0t: display_cs expected 0 actual 1 during the %s",
                     $time, what);
            frame_errors++;
        end
        if (dc_bad)
        begin
            $display("Fail at time %0t: display_dc expected %b actual %b during the %s",
                     $time, want_dc, !want_dc, what);
            frame_errors++;
        end
    endtask

    //////////////////////////////
    // Frame decoding
    //////////////////////////////
    task automatic check_frame();
        string       name;
        logic [15:0] got;
        logic [15:0] want;
        logic        ok;
        int          waited;
        int          i;
        name         = name_q.pop_front();
        frame_errors = 0;
        get_bits(8, 1'b0, "command byte", got, ok);
        if (ok && got[7:0] !== CMD_BYTE)
        begin
            $display("Fail at time %0t: display_mosi command byte expected %h actual %h",
                     $time, CMD_BYTE, got[7:0]);
            frame_errors++;
        end
        for (i = 0; i < TILE_PIXELS; i++)
        begin
            want = exp_q.pop_front();
            if (ok)
            begin
                get_bits(16, 1'b1, $sformatf("pixel %0d", i), got, ok);
                if (ok && got !== want)
                begin
                    $display("Fail at time %0t: display_mosi pixel %0d expected %h actual %h",
                             $time, i, want, got);
                    frame_errors++;
                end
            end
        end
        // Display released after the last pixel
        waited = 0;
        while (display_cs !== 1'b1 && waited < BIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (display_cs !== 1'b1)
        begin
            $display("Time %0t: display_cs stayed low after the last pixel", $time);
            frame_errors++;
        end
        else if (ok && bit_q.size() != 0)
        begin
            $display("Time %0t: %0d extra display_sck rises in the frame", $time, bit_q.size());
            frame_errors++;
        end
        bit_q.delete();
        error_count += frame_errors;
        frames_done++;
        finish_test(name, frame_errors);
    endtask

    initial
    begin
        check_reset_state();
        forever
        begin
            @(negedge clk);
            if (name_q.size() != 0)
                check_frame();
        end
    end

endmodule

/* testbench/tb_raster_display.sv */
/*
 * Raster display path testbench
 * Sends host commands over the serial link from a stimulus table and keeps
 * a reference tile, handing each expected frame to the display checker
 */
module tb_raster_display;
    import raster_pkg::*;

    localparam int          TILE_PIXELS = 32;
    localparam int          CLOCK_DIV   = 2;
    localparam int          SER_HALF    = 4;
    localparam int          DRIVE_DELAY = 5;
    localparam int          WAIT_LIMIT  = 8000;
    localparam logic [31:0] LCG_SEED    = 32'd48687;

    logic clk;
    logic rst_n;
    logic serial_sck;
    logic serial_mosi;
    logic serial_cs;
    logic serial_cts;
    logic display_sck;
    logic display_mosi;
    logic display_cs;
    logic display_dc;

    // Stimulus table
    opcode_t     tbl_op [$];
    logic [23:0] tbl_payload [$];
    logic        tbl_wait [$];
    logic        tbl_stall [$];
    string       tbl_name [$];

    // Reference tile
    pixel_t      model [TILE_PIXELS];
    logic [31:0] lcg_state;
    int          frames_sent;
    int          tests_expected;
    logic        aborted;
    int          idx;

    raster_display_top #(
        .TILE_PIXELS(TILE_PIXELS),
        .CLOCK_DIV(CLOCK_DIV)
    ) raster_display_top_inst (
        .clk(clk),
        .rst_n(rst_n),
        .serial_sck(serial_sck),
        .serial_mosi(serial_mosi),
        .serial_cs(serial_cs),
        .serial_cts(serial_cts),
        .display_sck(display_sck),
        .display_mosi(display_mosi),
        .display_cs(display_cs),
        .display_dc(display_dc)
    );

    display_checker #(
        .TILE_PIXELS(TILE_PIXELS)
    ) display_checker_inst (
        .clk(clk),
        .rst_n(rst_n),
        .serial_cts(serial_cts),
        .display_sck(display_sck),
        .display_mosi(display_mosi),
        .display_cs(display_cs),
        .display_dc(display_dc)
    );

    always #20 clk = ~clk;

    function automatic pixel_t next_random_pixel();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    task automatic add_entry(input opcode_t op, input logic [23:0] payload,
                             input logic wait_done, input logic stall, input string name);
        tbl_op.push_back(op);
        tbl_payload.push_back(payload);
        tbl_wait.push_back(wait_done);
        tbl_stall.push_back(stall);
        tbl_name.push_back(name);
    endtask

    task automatic load_table();
        // opcode, payload, wait for frames, expect cts stall, test name
        add_entry(OP_FILL,  24'h00_1234,     1'b0, 1'b0, "");
        add_entry(OP_FLUSH, 24'h00_0000,     1'b1, 1'b0, "fill then flush");
        add_entry(OP_WRITE, {8'd5, 16'd7},   1'b0, 1'b0, "");
        add_entry(OP_FLUSH, 24'h00_0000,     1'b1, 1'b0, "pixel run over fill");
        add_entry(OP_WRITE, {8'd6, 16'd29},  1'b0, 1'b0, "");
        add_entry(OP_FLUSH, 24'h00_0000,     1'b1, 1'b0, "run wrapping to address 0");
        add_entry(8'h7F,    24'hAB_CDEF,     1'b0, 1'b0, "");
        add_entry(OP_FLUSH, 24'h00_0000,     1'b1, 1'b0, "unknown opcode ignored");
        // Back to back from here, the flush is still running
        add_entry(OP_FLUSH, 24'h00_0000,     1'b0, 1'b0, "flush under traffic");
        add_entry(OP_FILL,  24'h00_F00F,     1'b0, 1'b0, "");
        add_entry(OP_WRITE, {8'd3, 16'd12},  1'b0, 1'b0, "");
        add_entry(OP_FLUSH, 24'h00_0000,     1'b1, 1'b1, "frame after stall");
    endtask

    //////////////////////////////
    // Serial host driver
    //////////////////////////////
    task automatic send_word(input cmd_word_t word);
        int waited;
        int b;
        if (!aborted)
        begin
            waited = 0;
            @(posedge clk);
            #DRIVE_DELAY;
            while (serial_cts !== 1'b1 && waited < WAIT_LIMIT)
            begin
                @(posedge clk);
                #DRIVE_DELAY;
                waited++;
            end
            if (serial_cts !== 1'b1)
            begin
                $display("Time %0t: serial_cts stayed low for %0d clocks", $time, WAIT_LIMIT);
                aborted = 1'b1;
            end
            else
            begin
                serial_cs = 1'b0;
                for (b = 31; b >= 0; b--)
                begin
                    serial_mosi = word[b];
                    repeat (SER_HALF) @(posedge clk);
                    #DRIVE_DELAY;
                    serial_sck = 1'b1;
                    repeat (SER_HALF) @(posedge clk);
                    #DRIVE_DELAY;
                    serial_sck = 1'b0;
                end
                repeat (SER_HALF) @(posedge clk);
                #DRIVE_DELAY;
                serial_cs = 1'b1;
            end
        end
    endtask

    // Sends one table entry and updates the reference tile
    task automatic apply_entry(input int n);
        pixel_t pixel;
        int     count;
        int     addr;
        int     i;
        send_word({tbl_op[n], tbl_payload[n]});
        case (tbl_op[n])
            OP_FILL:
            begin
                for (i = 0; i < TILE_PIXELS; i++)
                    model[i] = tbl_payload[n][15:0];
            end
            OP_WRITE:
            begin
                count = int'(tbl_payload[n][23:16]);
                addr  = int'(tbl_payload[n][15:0]);
                for (i = 0; i < count; i++)
                begin
                    pixel = next_random_pixel();
                    send_word({16'h0000, pixel});
                    model[(addr + i) % TILE_PIXELS] = pixel;
                end
            end
            OP_FLUSH:
            begin
                for (i = 0; i < TILE_PIXELS; i++)
                    display_checker_inst.push_pixel(model[i]);
                display_checker_inst.push_frame(tbl_name[n]);
                frames_sent++;
                tests_expected++;
            end
            default:
            begin
                // Tile untouched
            end
        endcase
    endtask

    task automatic wait_frames_done();
        int waited;
        waited = 0;
        while (display_checker_inst.frames_done != frames_sent && waited < WAIT_LIMIT)
        begin
            @(posedge clk);
            waited++;
        end
        if (display_checker_inst.frames_done != frames_sent)
        begin
            $display("Time %0t: checker finished %0d of %0d frames in time",
                     $time, display_checker_inst.frames_done, frames_sent);
            aborted = 1'b1;
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial
    begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        serial_sck     = 1'b0;
        serial_mosi    = 1'b0;
        serial_cs      = 1'b1;
        lcg_state      = LCG_SEED;
        aborted        = 1'b0;
        frames_sent    = 0;
        tests_expected = 1;
        load_table();
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        repeat (4) @(posedge clk);

        for (idx = 0; idx < tbl_op.size() && !aborted; idx++)
        begin
            apply_entry(idx);
            if (tbl_wait[idx] && !aborted)
                wait_frames_done();
            if (tbl_stall[idx] && !aborted)
            begin
                display_checker_inst.check_stall("back to back stall");
                tests_expected++;
            end
        end
        if (!aborted)
            wait_frames_done();

        $display("Tests run %0d of %0d, failed %0d, errors %0d",
                 display_checker_inst.tests_run, tests_expected,
                 display_checker_inst.tests_failed, display_checker_inst.error_count);
        if (aborted || display_checker_inst.tests_failed != 0 ||
            display_checker_inst.error_count != 0 ||
            display_checker_inst.tests_run != tests_expected)
            $display("Simulation finished: FAIL");
        else
            $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* sources.f */
rtl/raster_pkg.sv
rtl/serial_word_rx.sv
rtl/cmd_parser_fsm.sv
rtl/tile_buffer.sv
rtl/spi_bit_timer.sv
rtl/display_spi_tx.sv
rtl/raster_display_top.sv
testbench/display_checker.sv
testbench/tb_raster_display.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the raster display testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_raster_display \
    -f sources.f -o sim_raster_display

output=$(./obj_dir/sim_raster_display)
echo "$output"

if echo "$output" | grep -q "Simulation finished: PASS"; then
    exit 0
else
    exit 1
fi
